// File: hw/kv_cfg_pkg.sv
// --------------------------------------------------------------------
// Key vault configuration constants: array sizes, client defaults,
// register map, KEY_CTRL and CLEAR_SECRETS bit positions, and the
// debug flush patterns. Referenced by scoped name from the RTL.
// --------------------------------------------------------------------
package kv_cfg_pkg;

    // array geometry
    parameter int KV_NUM_KEYS   = 8;
    parameter int KV_NUM_DWORDS = 16;
    parameter int KV_ENTRY_W    = 3;
    parameter int KV_DWORD_W    = 4;

    // default client counts for the top level
    parameter int KV_NUM_READ_DEF  = 3;
    parameter int KV_NUM_WRITE_DEF = 2;

    // width of the per-entry dest_valid mask, caps the read client count
    parameter int KV_MAX_READ = 4;

    // entry routed to the signing key output
    parameter int KV_ENTRY_FOR_SIGNING = 7;

    // flush patterns, chosen by sel_debug_value
    parameter logic [31:0] KV_DEBUG_VALUE_0 = 32'haaaa_aaaa;
    parameter logic [31:0] KV_DEBUG_VALUE_1 = 32'h5555_5555;

    // register map
    parameter int KV_REG_AW = 8;
    parameter logic [KV_REG_AW-1:0] KV_ADDR_KEY_CTRL_BASE = 8'h00;
    parameter logic [KV_REG_AW-1:0] KV_ADDR_CLEAR_SECRETS = 8'h40;

    // KEY_CTRL fields
    parameter int KV_CTRL_LOCK_WR_BIT    = 0;
    parameter int KV_CTRL_LOCK_USE_BIT   = 1;
    parameter int KV_CTRL_CLEAR_BIT      = 2;
    parameter int KV_CTRL_DEST_VALID_LSB = 4;
    parameter int KV_CTRL_LAST_DWORD_LSB = 8;

    // CLEAR_SECRETS fields
    parameter int KV_CLR_WR_DEBUG_BIT  = 0;
    parameter int KV_CLR_SEL_DEBUG_BIT = 1;

endpackage

// File: hw/kv_if_pkg.sv
// --------------------------------------------------------------------
// Key vault interface types: client write and read requests with
// their responses, the firmware register request, and the control
// state kept per key entry.
// --------------------------------------------------------------------
package kv_if_pkg;

    // crypto client write, one dword per cycle
    typedef struct packed {
        logic                                write_en;
        logic [kv_cfg_pkg::KV_ENTRY_W-1:0]   write_entry;
        logic [kv_cfg_pkg::KV_DWORD_W-1:0]   write_offset;
        logic [31:0]                         write_data;
        logic [kv_cfg_pkg::KV_MAX_READ-1:0]  write_dest_valid;
    } kv_write_t;

    typedef struct packed {
        logic error;
    } kv_wr_resp_t;

    // crypto client read, answered combinationally
    typedef struct packed {
        logic [kv_cfg_pkg::KV_ENTRY_W-1:0] read_entry;
        logic [kv_cfg_pkg::KV_DWORD_W-1:0] read_offset;
    } kv_read_t;

    typedef struct packed {
        logic [31:0] read_data;
        logic        last;
        logic        error;
    } kv_rd_resp_t;

    // control state of one key entry
    typedef struct packed {
        logic                                lock_wr;
        logic                                lock_use;
        logic [kv_cfg_pkg::KV_MAX_READ-1:0]  dest_valid;
        logic [kv_cfg_pkg::KV_DWORD_W-1:0]   last_dword;
    } kv_entry_ctrl_t;

    // single-cycle firmware register access
    typedef struct packed {
        logic                               req;
        logic                               write;
        logic [kv_cfg_pkg::KV_REG_AW-1:0]   addr;
        logic [31:0]                        wdata;
    } kv_reg_req_t;

endpackage

// File: hw/kv_ctrl.sv
// --------------------------------------------------------------------
// Key vault control. Decodes firmware register accesses, keeps the
// sticky locks, dest_valid and last_dword of every entry, and turns
// client writes, clears and flushes into strobes for the storage.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kv_ctrl #(
    parameter int NUM_READ  = kv_cfg_pkg::KV_NUM_READ_DEF,
    parameter int NUM_WRITE = kv_cfg_pkg::KV_NUM_WRITE_DEF
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n_i,
    input  kv_if_pkg::kv_reg_req_t                                reg_req_i,
    input  logic                                                  debug_unlock_i,
    input  kv_if_pkg::kv_write_t [NUM_WRITE-1:0]                  kv_write_i,
    output logic [31:0]                                           reg_rdata_o,
    output logic                                                  reg_err_o,
    output kv_if_pkg::kv_wr_resp_t [NUM_WRITE-1:0]                kv_wr_resp_o,
    output kv_if_pkg::kv_entry_ctrl_t [kv_cfg_pkg::KV_NUM_KEYS-1:0] entry_ctrl_o,
    output logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]                    entry_wr_allow_o,
    output logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]                    clear_pulse_o,
    output logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]                    flush_en_o,
    output logic [31:0]                                           flush_value_o
);

    localparam int NK = kv_cfg_pkg::KV_NUM_KEYS;
    localparam int MR = kv_cfg_pkg::KV_MAX_READ;

    logic [kv_cfg_pkg::KV_REG_AW-1:0]  key_off;
    logic [kv_cfg_pkg::KV_ENTRY_W-1:0] key_sel;
    logic                              key_hit;
    logic                              clr_hit;
    logic                              key_wr;
    logic                              clr_wr;
    logic                              wr_debug_pulse;
    logic                              sel_debug_q;
    logic                              sel_debug_d;
    logic [NK-1:0]                     entry_locked;
    logic [MR-1:0]                     read_mask;

    kv_if_pkg::kv_entry_ctrl_t [NK-1:0] entry_q;
    kv_if_pkg::kv_entry_ctrl_t [NK-1:0] entry_d;

    // address decode, KEY_CTRL registers are dword spaced from the base
    always_comb begin
        key_off = reg_req_i.addr - kv_cfg_pkg::KV_ADDR_KEY_CTRL_BASE;
        key_hit = (key_off < (NK * 4)) && (key_off[1:0] == 2'b00);
        key_sel = key_off[kv_cfg_pkg::KV_ENTRY_W+1:2];
        clr_hit = (reg_req_i.addr == kv_cfg_pkg::KV_ADDR_CLEAR_SECRETS);
        key_wr  = reg_req_i.req & reg_req_i.write & key_hit;
        clr_wr  = reg_req_i.req & reg_req_i.write & clr_hit;
    end

    // register read path and unmapped access error
    always_comb begin
        reg_rdata_o = '0;
        reg_err_o   = reg_req_i.req & ~(key_hit | clr_hit);
        if (reg_req_i.req && !reg_req_i.write && key_hit) begin
            reg_rdata_o[kv_cfg_pkg::KV_CTRL_LOCK_WR_BIT]  = entry_q[key_sel].lock_wr;
            reg_rdata_o[kv_cfg_pkg::KV_CTRL_LOCK_USE_BIT] = entry_q[key_sel].lock_use;
            reg_rdata_o[kv_cfg_pkg::KV_CTRL_DEST_VALID_LSB +: MR] = entry_q[key_sel].dest_valid;
            reg_rdata_o[kv_cfg_pkg::KV_CTRL_LAST_DWORD_LSB +: kv_cfg_pkg::KV_DWORD_W] =
                entry_q[key_sel].last_dword;
        end else if (reg_req_i.req && !reg_req_i.write && clr_hit) begin
            reg_rdata_o[kv_cfg_pkg::KV_CLR_SEL_DEBUG_BIT] = sel_debug_q;
        end
    end

    // a flush written together with a new selection uses the new pattern
    always_comb begin
        wr_debug_pulse = clr_wr & reg_req_i.wdata[kv_cfg_pkg::KV_CLR_WR_DEBUG_BIT];
        sel_debug_d    = clr_wr ? reg_req_i.wdata[kv_cfg_pkg::KV_CLR_SEL_DEBUG_BIT] : sel_debug_q;
        flush_value_o  = sel_debug_d ? kv_cfg_pkg::KV_DEBUG_VALUE_1 :
                                       kv_cfg_pkg::KV_DEBUG_VALUE_0;
    end

    // only the configured read clients may be granted access
    always_comb begin
        for (int i = 0; i < MR; i++) begin
            read_mask[i] = (i < NUM_READ);
        end
    end

    // clear and flush strobes, debug unlock overrides the locks
    always_comb begin
        for (int e = 0; e < NK; e++) begin
            entry_locked[e]  = entry_q[e].lock_wr | entry_q[e].lock_use;
            clear_pulse_o[e] = key_wr & (key_sel == e) &
                               reg_req_i.wdata[kv_cfg_pkg::KV_CTRL_CLEAR_BIT] & ~entry_locked[e];
            flush_en_o[e]    = debug_unlock_i | (wr_debug_pulse & ~entry_locked[e]);
        end
    end

    // client write error when the target entry has either lock set
    always_comb begin
        for (int c = 0; c < NUM_WRITE; c++) begin
            kv_wr_resp_o[c].error = kv_write_i[c].write_en &
                                    entry_locked[kv_write_i[c].write_entry];
        end
    end

    // next control state per entry
    always_comb begin
        logic                            wr_hit;
        logic [MR-1:0]                   dv_next;
        logic [kv_cfg_pkg::KV_DWORD_W-1:0] last_next;

        entry_d = entry_q;
        for (int e = 0; e < NK; e++) begin
            wr_hit    = 1'b0;
            dv_next   = '0;
            last_next = '0;
            // OR over all writers targeting this entry
            for (int c = 0; c < NUM_WRITE; c++) begin
                if (kv_write_i[c].write_en && (kv_write_i[c].write_entry == e)) begin
                    wr_hit    = 1'b1;
                    dv_next   = dv_next | kv_write_i[c].write_dest_valid;
                    last_next = last_next | kv_write_i[c].write_offset;
                end
            end
            entry_wr_allow_o[e] = wr_hit & ~entry_locked[e];

            // locks only ever get set, reset is the way out
            if (key_wr && (key_sel == e)) begin
                entry_d[e].lock_wr  = entry_q[e].lock_wr |
                                      reg_req_i.wdata[kv_cfg_pkg::KV_CTRL_LOCK_WR_BIT];
                entry_d[e].lock_use = entry_q[e].lock_use |
                                      reg_req_i.wdata[kv_cfg_pkg::KV_CTRL_LOCK_USE_BIT];
            end

            if (clear_pulse_o[e]) begin
                entry_d[e].dest_valid = '0;
                entry_d[e].last_dword = '0;
            end else if (entry_wr_allow_o[e]) begin
                entry_d[e].dest_valid = dv_next & read_mask;
                entry_d[e].last_dword = last_next;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            entry_q     <= '0;
            sel_debug_q <= 1'b0;
        end else begin
            entry_q     <= entry_d;
            sel_debug_q <= sel_debug_d;
        end
    end

    assign entry_ctrl_o = entry_q;

endmodule

// File: hw/kv_store.sv
// --------------------------------------------------------------------
// Key vault storage array. Each dword loads the flush pattern, zero
// on a clear, or client data picked by an AND-OR mux, in that order
// of priority. All strobes arrive already qualified by kv_ctrl.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kv_store #(
    parameter int NUM_WRITE = kv_cfg_pkg::KV_NUM_WRITE_DEF
) (
    input  logic                                        clk,
    input  logic                                        rst_n_i,
    input  kv_if_pkg::kv_write_t [NUM_WRITE-1:0]        kv_write_i,
    input  logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]          entry_wr_allow_i,
    input  logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]          clear_pulse_i,
    input  logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]          flush_en_i,
    input  logic [31:0]                                 flush_value_i,
    output logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]
                 [kv_cfg_pkg::KV_NUM_DWORDS-1:0][31:0]  key_data_o
);

    localparam int NK = kv_cfg_pkg::KV_NUM_KEYS;
    localparam int ND = kv_cfg_pkg::KV_NUM_DWORDS;

    logic [NK-1:0][ND-1:0]       dword_we;
    logic [NK-1:0][ND-1:0][31:0] dword_next;
    logic [NK-1:0][ND-1:0][31:0] key_q;

    always_comb begin
        logic        hit;
        logic        wr_sel;
        logic [31:0] wr_data;

        for (int e = 0; e < NK; e++) begin
            for (int d = 0; d < ND; d++) begin
                wr_sel  = 1'b0;
                wr_data = '0;
                // AND-OR mux over the write clients
                for (int c = 0; c < NUM_WRITE; c++) begin
                    hit     = kv_write_i[c].write_en &
                              (kv_write_i[c].write_entry == e) &
                              (kv_write_i[c].write_offset == d);
                    wr_sel  = wr_sel | hit;
                    wr_data = wr_data | ({32{hit}} & kv_write_i[c].write_data);
                end
                wr_sel = wr_sel & entry_wr_allow_i[e];

                dword_we[e][d] = flush_en_i[e] | clear_pulse_i[e] | wr_sel;
                if (flush_en_i[e]) begin
                    dword_next[e][d] = flush_value_i;
                end else if (clear_pulse_i[e]) begin
                    dword_next[e][d] = '0;
                end else begin
                    dword_next[e][d] = wr_data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            key_q <= '0;
        end else begin
            for (int e = 0; e < NK; e++) begin
                for (int d = 0; d < ND; d++) begin
                    if (dword_we[e][d]) begin
                        key_q[e][d] <= dword_next[e][d];
                    end
                end
            end
        end
    end

    assign key_data_o = key_q;

endmodule

// File: hw/kv_read_mux.sv
// --------------------------------------------------------------------
// Key vault read mux. Every read client gets its dword from the key
// array in the same cycle, zeroed with error set unless the entry is
// usable and grants this client in dest_valid.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kv_read_mux #(
    parameter int NUM_READ = kv_cfg_pkg::KV_NUM_READ_DEF
) (
    input  kv_if_pkg::kv_read_t [NUM_READ-1:0]                  kv_read_i,
    input  logic [kv_cfg_pkg::KV_NUM_KEYS-1:0]
                 [kv_cfg_pkg::KV_NUM_DWORDS-1:0][31:0]          key_data_i,
    input  kv_if_pkg::kv_entry_ctrl_t [kv_cfg_pkg::KV_NUM_KEYS-1:0] entry_ctrl_i,
    output kv_if_pkg::kv_rd_resp_t [NUM_READ-1:0]               kv_rd_resp_o
);

    localparam int NK = kv_cfg_pkg::KV_NUM_KEYS;

    always_comb begin
        logic        sel;
        logic        denied;
        logic [31:0] dword;

        for (int c = 0; c < NUM_READ; c++) begin
            kv_rd_resp_o[c] = '0;
            // AND-OR across entries, only the addressed one contributes
            for (int e = 0; e < NK; e++) begin
                sel    = (kv_read_i[c].read_entry == e);
                denied = entry_ctrl_i[e].lock_use | ~entry_ctrl_i[e].dest_valid[c];
                dword  = key_data_i[e][kv_read_i[c].read_offset];

                kv_rd_resp_o[c].read_data = kv_rd_resp_o[c].read_data |
                                            ({32{sel & ~denied}} & dword);
                kv_rd_resp_o[c].error     = kv_rd_resp_o[c].error | (sel & denied);
                // last dword as recorded by the final client write
                kv_rd_resp_o[c].last      = kv_rd_resp_o[c].last |
                    (sel & (kv_read_i[c].read_offset == entry_ctrl_i[e].last_dword));
            end
        end
    end

endmodule

// File: hw/kv_top.sv
// --------------------------------------------------------------------
// Key vault top level. Connects the register and control block, the
// key storage and the read mux, and drives the signing key output
// from the dedicated signing entry. Client counts are set here.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kv_top #(
    parameter int NUM_READ  = kv_cfg_pkg::KV_NUM_READ_DEF,
    parameter int NUM_WRITE = kv_cfg_pkg::KV_NUM_WRITE_DEF
) (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  logic                                           debug_unlock_i,
    // firmware register port
    input  kv_if_pkg::kv_reg_req_t                         reg_req_i,
    output logic [31:0]                                    reg_rdata_o,
    output logic                                           reg_err_o,
    // crypto client ports
    input  kv_if_pkg::kv_write_t [NUM_WRITE-1:0]           kv_write_i,
    output kv_if_pkg::kv_wr_resp_t [NUM_WRITE-1:0]         kv_wr_resp_o,
    input  kv_if_pkg::kv_read_t [NUM_READ-1:0]             kv_read_i,
    output kv_if_pkg::kv_rd_resp_t [NUM_READ-1:0]          kv_rd_resp_o,
    output logic [kv_cfg_pkg::KV_NUM_DWORDS-1:0][31:0]     signing_key_o
);

    localparam int NK = kv_cfg_pkg::KV_NUM_KEYS;
    localparam int ND = kv_cfg_pkg::KV_NUM_DWORDS;

    kv_if_pkg::kv_entry_ctrl_t [NK-1:0] entry_ctrl;
    logic [NK-1:0]                      entry_wr_allow;
    logic [NK-1:0]                      clear_pulse;
    logic [NK-1:0]                      flush_en;
    logic [31:0]                        flush_value;
    logic [NK-1:0][ND-1:0][31:0]        key_data;

    kv_ctrl #(
        .NUM_READ  (NUM_READ),
        .NUM_WRITE (NUM_WRITE)
    ) i_kv_ctrl (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .reg_req_i        (reg_req_i),
        .debug_unlock_i   (debug_unlock_i),
        .kv_write_i       (kv_write_i),
        .reg_rdata_o      (reg_rdata_o),
        .reg_err_o        (reg_err_o),
        .kv_wr_resp_o     (kv_wr_resp_o),
        .entry_ctrl_o     (entry_ctrl),
        .entry_wr_allow_o (entry_wr_allow),
        .clear_pulse_o    (clear_pulse),
        .flush_en_o       (flush_en),
        .flush_value_o    (flush_value)
    );

    kv_store #(
        .NUM_WRITE (NUM_WRITE)
    ) i_kv_store (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .kv_write_i       (kv_write_i),
        .entry_wr_allow_i (entry_wr_allow),
        .clear_pulse_i    (clear_pulse),
        .flush_en_i       (flush_en),
        .flush_value_i    (flush_value),
        .key_data_o       (key_data)
    );

    kv_read_mux #(
        .NUM_READ (NUM_READ)
    ) i_kv_read_mux (
        .kv_read_i    (kv_read_i),
        .key_data_i   (key_data),
        .entry_ctrl_i (entry_ctrl),
        .kv_rd_resp_o (kv_rd_resp_o)
    );

    // signing entry goes out unconditionally, no lock or dest_valid check
    assign signing_key_o = key_data[kv_cfg_pkg::KV_ENTRY_FOR_SIGNING];

endmodule

// File: verif/kv_assertions.sv
// --------------------------------------------------------------------
// Concurrent checks on the key vault, bound into kv_top. Covers
// denied reads, writes to locked entries, sticky locks and the
// register error output.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kv_assertions #(
    parameter int NUM_READ  = kv_cfg_pkg::KV_NUM_READ_DEF,
    parameter int NUM_WRITE = kv_cfg_pkg::KV_NUM_WRITE_DEF
) (
    input logic                                                   clk,
    input logic                                                   rst_n_i,
    input kv_if_pkg::kv_reg_req_t                                 reg_req_i,
    input logic                                                   reg_err_i,
    input kv_if_pkg::kv_write_t [NUM_WRITE-1:0]                   wr_req_i,
    input kv_if_pkg::kv_wr_resp_t [NUM_WRITE-1:0]                 wr_resp_i,
    input kv_if_pkg::kv_read_t [NUM_READ-1:0]                     rd_req_i,
    input kv_if_pkg::kv_rd_resp_t [NUM_READ-1:0]                  rd_resp_i,
    input kv_if_pkg::kv_entry_ctrl_t [kv_cfg_pkg::KV_NUM_KEYS-1:0] entry_ctrl_i
);

    int fail_count = 0;

    // a client without its dest_valid bit sees zero data and an error
    for (genvar c = 0; c < NUM_READ; c++) begin : g_read
        a_denied_read: assert property (@(posedge clk) disable iff (!rst_n_i)
            !entry_ctrl_i[rd_req_i[c].read_entry].dest_valid[c]
            |-> (rd_resp_i[c].error && (rd_resp_i[c].read_data == '0)))
        else begin
            fail_count++;
            $error("read without dest_valid returned data or no error");
        end
    end

    // either lock on the target entry rejects a client write
    for (genvar c = 0; c < NUM_WRITE; c++) begin : g_write
        a_locked_write: assert property (@(posedge clk) disable iff (!rst_n_i)
            (wr_req_i[c].write_en &&
             (entry_ctrl_i[wr_req_i[c].write_entry].lock_wr ||
              entry_ctrl_i[wr_req_i[c].write_entry].lock_use))
            |-> wr_resp_i[c].error)
        else begin
            fail_count++;
            $error("write to a locked entry gave no error");
        end
    end

    // locks hold until reset
    for (genvar e = 0; e < kv_cfg_pkg::KV_NUM_KEYS; e++) begin : g_lock
        a_lock_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
            (entry_ctrl_i[e].lock_wr || entry_ctrl_i[e].lock_use)
            |=> ((entry_ctrl_i[e].lock_wr  >= $past(entry_ctrl_i[e].lock_wr)) &&
                 (entry_ctrl_i[e].lock_use >= $past(entry_ctrl_i[e].lock_use))))
        else begin
            fail_count++;
            $error("lock bit cleared without reset");
        end
    end

    a_reg_err_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        !reg_req_i.req |-> !reg_err_i)
    else begin
        fail_count++;
        $error("register error raised without a request");
    end

endmodule

// File: verif/kv_tb.sv
// --------------------------------------------------------------------
// Directed testbench for the key vault. Runs write/read, lock, clear,
// flush and register tests, prints one line per test and a verdict.
// Concurrent checks come from kv_assertions, bound into kv_top.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kv_tb;

    localparam int NR = kv_cfg_pkg::KV_NUM_READ_DEF;
    localparam int NW = kv_cfg_pkg::KV_NUM_WRITE_DEF;
    localparam int ND = kv_cfg_pkg::KV_NUM_DWORDS;

    logic                           clk;
    logic                           rst_n;
    logic                           debug_unlock;
    kv_if_pkg::kv_reg_req_t         reg_req;
    logic [31:0]                    reg_rdata;
    logic                           reg_err;
    kv_if_pkg::kv_write_t [NW-1:0]  kv_write;
    kv_if_pkg::kv_wr_resp_t [NW-1:0] kv_wr_resp;
    kv_if_pkg::kv_read_t [NR-1:0]   kv_read;
    kv_if_pkg::kv_rd_resp_t [NR-1:0] kv_rd_resp;
    logic [ND-1:0][31:0]            signing_key;

    int err_count;
    int err_at_start;
    int tests_ok;
    int tests_bad;

    kv_top i_kv_top (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .debug_unlock_i (debug_unlock),
        .reg_req_i      (reg_req),
        .reg_rdata_o    (reg_rdata),
        .reg_err_o      (reg_err),
        .kv_write_i     (kv_write),
        .kv_wr_resp_o   (kv_wr_resp),
        .kv_read_i      (kv_read),
        .kv_rd_resp_o   (kv_rd_resp),
        .signing_key_o  (signing_key)
    );

    bind kv_top kv_assertions #(
        .NUM_READ  (NUM_READ),
        .NUM_WRITE (NUM_WRITE)
    ) i_kv_assertions (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .reg_req_i    (reg_req_i),
        .reg_err_i    (reg_err_o),
        .wr_req_i     (kv_write_i),
        .wr_resp_i    (kv_wr_resp_o),
        .rd_req_i     (kv_read_i),
        .rd_resp_i    (kv_rd_resp_o),
        .entry_ctrl_i (entry_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int total_errors();
        return err_count + i_kv_top.i_kv_assertions.fail_count;
    endfunction

    function automatic logic [7:0] key_ctrl_addr(input int entry);
        return kv_cfg_pkg::KV_ADDR_KEY_CTRL_BASE + 8'(4 * entry);
    endfunction

    // KEY_CTRL readback: last_dword 11:8, dest_valid 7:4, lock_use 1, lock_wr 0
    function automatic logic [31:0] ctrl_word(input logic lwr, input logic luse,
                                              input logic [3:0] dv, input logic [3:0] last);
        return {20'h0, last, dv, 2'b00, luse, lwr};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (total_errors() == err_at_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, total_errors() - err_at_start);
        end
        err_at_start = total_errors();
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_req <= '{req: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        reg_req <= '0;
    endtask

    task automatic reg_check(input string name, input logic [7:0] addr,
                             input logic [31:0] exp_data, input logic exp_err);
        @(posedge clk);
        reg_req <= '{req: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
        @(negedge clk);
        check_value(name, exp_data, reg_rdata);
        check_value(name, 32'(exp_err), 32'(reg_err));
        @(posedge clk);
        reg_req <= '0;
    endtask

    // one client write, error sampled while write_en is high
    task automatic client_write(input string name, input int c, input int entry,
                                input int offset, input logic [31:0] data,
                                input logic [3:0] dv, input logic exp_err);
        @(posedge clk);
        kv_write[c] <= '{write_en: 1'b1, write_entry: 3'(entry), write_offset: 4'(offset),
                         write_data: data, write_dest_valid: dv};
        @(negedge clk);
        check_value(name, 32'(exp_err), 32'(kv_wr_resp[c].error));
        @(posedge clk);
        kv_write[c] <= '0;
    endtask

    task automatic read_check(input string name, input int c, input int entry,
                              input int offset, input logic [31:0] exp_data,
                              input logic exp_last, input logic exp_err);
        @(posedge clk);
        kv_read[c] <= '{read_entry: 3'(entry), read_offset: 4'(offset)};
        @(negedge clk);
        check_value(name, exp_data, kv_rd_resp[c].read_data);
        check_value(name, 32'(exp_last), 32'(kv_rd_resp[c].last));
        check_value(name, 32'(exp_err), 32'(kv_rd_resp[c].error));
    endtask

    task automatic signing_check(input string name, input logic [31:0] exp);
        @(negedge clk);
        for (int d = 0; d < ND; d++) begin
            check_value(name, exp, signing_key[d]);
        end
    endtask

    initial begin
        logic [31:0] wdata [4];
        logic [31:0] word;
        int          n;

        void'($urandom(32'hb6d47da9));
        err_count    = 0;
        err_at_start = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        rst_n        = 1'b0;
        debug_unlock = 1'b0;
        reg_req      = '0;
        kv_write     = '0;
        kv_read      = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        n = 0;
        while (n < 20 && !(signing_key == '0 && !reg_err)) begin
            @(negedge clk);
            n++;
        end
        if (n == 20) begin
            $display("timeout: outputs did not settle after reset");
            err_count++;
        end

        // entry 2 granted to read client 1 only
        for (int i = 0; i < 4; i++) begin
            wdata[i] = $urandom();
            client_write("write_read", 0, 2, i, wdata[i], 4'b0010, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            read_check("write_read", 1, 2, i, wdata[i], i == 3, 1'b0);
        end
        read_check("write_read", 0, 2, 0, 32'h0, 1'b0, 1'b1);
        end_test("write_read");

        reg_write(key_ctrl_addr(2), 32'h1);
        client_write("lock_wr", 0, 2, 1, ~wdata[1], 4'b0010, 1'b1);
        read_check("lock_wr", 1, 2, 1, wdata[1], 1'b0, 1'b0);
        end_test("lock_wr");

        word = $urandom();
        client_write("lock_use", 1, 3, 1, word, 4'b0001, 1'b0);
        read_check("lock_use", 0, 3, 1, word, 1'b1, 1'b0);
        reg_write(key_ctrl_addr(3), 32'h2);
        read_check("lock_use", 0, 3, 1, 32'h0, 1'b1, 1'b1);
        // clear is ignored on a locked entry
        reg_write(key_ctrl_addr(3), 32'h4);
        reg_check("lock_use", key_ctrl_addr(3), ctrl_word(1'b0, 1'b1, 4'b0001, 4'd1), 1'b0);
        end_test("lock_use");

        word = $urandom();
        client_write("clear", 0, 4, 0, word, 4'b0100, 1'b0);
        read_check("clear", 2, 4, 0, word, 1'b1, 1'b0);
        reg_write(key_ctrl_addr(4), 32'h4);
        read_check("clear", 2, 4, 0, 32'h0, 1'b1, 1'b1);
        reg_check("clear", key_ctrl_addr(4), 32'h0, 1'b0);
        end_test("clear");

        word = $urandom();
        client_write("flush", 0, 7, 5, word, 4'b0001, 1'b0);
        reg_write(kv_cfg_pkg::KV_ADDR_CLEAR_SECRETS, 32'h3);
        signing_check("flush", kv_cfg_pkg::KV_DEBUG_VALUE_1);
        read_check("flush", 0, 7, 5, kv_cfg_pkg::KV_DEBUG_VALUE_1, 1'b1, 1'b0);
        read_check("flush", 1, 2, 0, wdata[0], 1'b0, 1'b0);
        // pattern 0 pulse must skip the now locked signing entry
        reg_write(key_ctrl_addr(7), 32'h1);
        reg_write(kv_cfg_pkg::KV_ADDR_CLEAR_SECRETS, 32'h1);
        signing_check("flush", kv_cfg_pkg::KV_DEBUG_VALUE_1);
        @(posedge clk);
        debug_unlock <= 1'b1;
        @(posedge clk);
        debug_unlock <= 1'b0;
        signing_check("flush", kv_cfg_pkg::KV_DEBUG_VALUE_0);
        read_check("flush", 1, 2, 0, kv_cfg_pkg::KV_DEBUG_VALUE_0, 1'b0, 1'b0);
        end_test("flush");

        reg_check("registers", key_ctrl_addr(2), ctrl_word(1'b1, 1'b0, 4'b0010, 4'd3), 1'b0);
        reg_check("registers", key_ctrl_addr(7), ctrl_word(1'b1, 1'b0, 4'b0001, 4'd5), 1'b0);
        reg_check("registers", 8'h44, 32'h0, 1'b1);
        reg_check("registers", 8'h02, 32'h0, 1'b1);
        end_test("registers");

        $display("tests ok %0d, tests failed %0d, errors %0d",
                 tests_ok, tests_bad, total_errors());
        if (total_errors() == 0 && tests_bad == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/kv_cfg_pkg.sv
hw/kv_if_pkg.sv
hw/kv_ctrl.sv
hw/kv_store.sv
hw/kv_read_mux.sv
hw/kv_top.sv
verif/kv_assertions.sv
verif/kv_tb.sv
